//--- hw/rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// ==============================
// Rename stage sizing
// ==============================

// Architectural registers seen by software
`define RN_ARCH_REGS 32

// Physical registers
// Lower half holds committed values, upper half is speculative
`define RN_PHYS_REGS 64

// Instructions renamed per cycle
`define RN_WIDTH 3

// Load/store queue entries
`define RN_LSQ_DEPTH 32

`endif

//--- hw/reg_map_pkg.sv
`include "rename_config.svh"

package reg_map_pkg;

    // ==============================
    // Register number widths
    // ==============================

    localparam int ARCH_REG_W = $clog2(`RN_ARCH_REGS);
    localparam int PHYS_REG_W = $clog2(`RN_PHYS_REGS);

    // Architectural register number, x0 reads as zero
    typedef logic [ARCH_REG_W-1:0] arch_reg_t;

    // Physical register number
    // 0 to 31 are committed, 32 to 63 are speculative
    typedef logic [PHYS_REG_W-1:0] phys_reg_t;

endpackage

//--- hw/lsq_pkg.sv
`include "rename_config.svh"

package lsq_pkg;

    // ==============================
    // Load/store queue types
    // ==============================

    localparam int LSQ_IDX_W = $clog2(`RN_LSQ_DEPTH);

    // Entry number in the load/store queue
    typedef logic [LSQ_IDX_W-1:0] lsq_idx_t;

    // Free entry count
    // One bit wider than an index so a full list fits
    typedef logic [LSQ_IDX_W:0] free_cnt_t;

endpackage

//--- hw/free_index_fifo.sv
`timescale 1ns/1ps

module free_index_fifo #(
    parameter int DEPTH = 32,
    parameter int FIRST = 0,
    localparam int IDX_W = $clog2(FIRST + DEPTH),
    localparam int PTR_W = $clog2(DEPTH),
    localparam int CNT_W = $clog2(DEPTH) + 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             flush,
    // Pops are compacted, pop_1 implies pop_0
    input  logic             pop_0,
    input  logic             pop_1,
    input  logic             pop_2,
    output logic [IDX_W-1:0] pop_idx_0,
    output logic [IDX_W-1:0] pop_idx_1,
    output logic [IDX_W-1:0] pop_idx_2,
    // Pushes may come on any subset of ports
    input  logic             push_0,
    input  logic             push_1,
    input  logic             push_2,
    input  logic [IDX_W-1:0] push_idx_0,
    input  logic [IDX_W-1:0] push_idx_1,
    input  logic [IDX_W-1:0] push_idx_2,
    output logic [CNT_W-1:0] free_count
);

    // Pointers wrap on their own, so DEPTH must be a power of two
    logic [IDX_W-1:0] entries [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic [1:0]       pop_n;
    logic [1:0]       push_n;
    logic [PTR_W-1:0] wr_ptr_1;
    logic [PTR_W-1:0] wr_ptr_2;

    assign pop_n  = 2'(pop_0) + 2'(pop_1) + 2'(pop_2);
    assign push_n = 2'(push_0) + 2'(push_1) + 2'(push_2);

    // Next three entries from the head
    assign pop_idx_0 = entries[head];
    assign pop_idx_1 = entries[head + PTR_W'(1)];
    assign pop_idx_2 = entries[head + PTR_W'(2)];

    // Each push lands behind the pushes of lower ports
    assign wr_ptr_1 = tail + PTR_W'(push_0);
    assign wr_ptr_2 = wr_ptr_1 + PTR_W'(push_1);

    assign free_count = count;

    // ==============================
    // Pointer and storage update
    // ==============================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= IDX_W'(FIRST + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= CNT_W'(DEPTH);
        end else if (flush) begin
            // Refill in the same order as after reset
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= IDX_W'(FIRST + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= CNT_W'(DEPTH);
        end else begin
            if (push_0) begin
                entries[tail] <= push_idx_0;
            end
            if (push_1) begin
                entries[wr_ptr_1] <= push_idx_1;
            end
            if (push_2) begin
                entries[wr_ptr_2] <= push_idx_2;
            end
            head  <= head + PTR_W'(pop_n);
            tail  <= tail + PTR_W'(push_n);
            count <= count - CNT_W'(pop_n) + CNT_W'(push_n);
        end
    end

endmodule

//--- hw/alias_table.sv
`timescale 1ns/1ps

`include "rename_config.svh"

module alias_table
    import reg_map_pkg::*;
    import lsq_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    // Decoded group
    input  logic [`RN_WIDTH-1:0] decode_valid,
    input  arch_reg_t            rs1_arch_0, rs1_arch_1, rs1_arch_2,
    input  arch_reg_t            rs2_arch_0, rs2_arch_1, rs2_arch_2,
    input  arch_reg_t            rd_arch_0, rd_arch_1, rd_arch_2,
    input  logic                 rd_write_enable_0, rd_write_enable_1, rd_write_enable_2,
    input  logic                 load_store_0, load_store_1, load_store_2,
    // Free list state at the start of the cycle
    input  free_cnt_t            reg_free_count,
    input  free_cnt_t            lsq_free_count,
    input  phys_reg_t            reg_free_idx_0, reg_free_idx_1, reg_free_idx_2,
    // Commit
    input  logic [`RN_WIDTH-1:0] commit_valid,
    input  arch_reg_t            commit_arch_0, commit_arch_1, commit_arch_2,
    input  phys_reg_t            commit_phys_0, commit_phys_1, commit_phys_2,
    // Rename results
    output phys_reg_t            rs1_phys_0, rs1_phys_1, rs1_phys_2,
    output phys_reg_t            rs2_phys_0, rs2_phys_1, rs2_phys_2,
    output phys_reg_t            rd_phys_0, rd_phys_1, rd_phys_2,
    output phys_reg_t            old_rd_phys_0, old_rd_phys_1, old_rd_phys_2,
    output logic [`RN_WIDTH-1:0] rename_valid,
    output logic [`RN_WIDTH-1:0] lsq_alloc_valid,
    // Compacted pops toward the free lists
    output logic                 reg_pop_0, reg_pop_1, reg_pop_2,
    output logic                 lsq_pop_0, lsq_pop_1, lsq_pop_2
);

    phys_reg_t map_table [`RN_ARCH_REGS];

    // Slot views of the loose ports
    arch_reg_t rs1_s    [`RN_WIDTH];
    arch_reg_t rs2_s    [`RN_WIDTH];
    arch_reg_t rd_s     [`RN_WIDTH];
    arch_reg_t cm_arch  [`RN_WIDTH];
    phys_reg_t cm_phys  [`RN_WIDTH];
    phys_reg_t free_idx [`RN_WIDTH];

    logic [`RN_WIDTH-1:0] need_reg;
    logic [`RN_WIDTH-1:0] need_lsq;
    logic [`RN_WIDTH-1:0] grant;
    logic [`RN_WIDTH-1:0] writes;
    logic                 blocked;
    free_cnt_t            reg_used;
    free_cnt_t            lsq_used;

    phys_reg_t new_p [`RN_WIDTH];
    phys_reg_t rs1_p [`RN_WIDTH];
    phys_reg_t rs2_p [`RN_WIDTH];
    phys_reg_t rd_p  [`RN_WIDTH];
    phys_reg_t old_p [`RN_WIDTH];

    assign rs1_s    = '{rs1_arch_0, rs1_arch_1, rs1_arch_2};
    assign rs2_s    = '{rs2_arch_0, rs2_arch_1, rs2_arch_2};
    assign rd_s     = '{rd_arch_0, rd_arch_1, rd_arch_2};
    assign cm_arch  = '{commit_arch_0, commit_arch_1, commit_arch_2};
    assign cm_phys  = '{commit_phys_0, commit_phys_1, commit_phys_2};
    assign free_idx = '{reg_free_idx_0, reg_free_idx_1, reg_free_idx_2};

    // x0 destinations take no register
    assign need_reg = decode_valid & {rd_write_enable_2 && (rd_arch_2 != '0),
                                      rd_write_enable_1 && (rd_arch_1 != '0),
                                      rd_write_enable_0 && (rd_arch_0 != '0)};
    assign need_lsq = decode_valid & {load_store_2, load_store_1, load_store_0};

    // ==============================
    // In-order grant
    // ==============================

    // A refused slot stops every higher slot of the group
    always_comb begin
        blocked  = flush;
        reg_used = '0;
        lsq_used = '0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            // Slot takes the free entry after those of lower slots
            new_p[i] = free_idx[reg_used[1:0]];
            grant[i] = decode_valid[i] && !blocked
                       && (reg_used + free_cnt_t'(need_reg[i]) <= reg_free_count)
                       && (lsq_used + free_cnt_t'(need_lsq[i]) <= lsq_free_count);
            if (grant[i]) begin
                reg_used = reg_used + free_cnt_t'(need_reg[i]);
                lsq_used = lsq_used + free_cnt_t'(need_lsq[i]);
            end else if (decode_valid[i]) begin
                blocked = 1'b1;
            end
        end
    end

    assign writes          = grant & need_reg;
    assign rename_valid    = grant;
    assign lsq_alloc_valid = grant & need_lsq;

    assign reg_pop_0 = (reg_used != '0);
    assign reg_pop_1 = (reg_used >= free_cnt_t'(2));
    assign reg_pop_2 = (reg_used >= free_cnt_t'(3));
    assign lsq_pop_0 = (lsq_used != '0);
    assign lsq_pop_1 = (lsq_used >= free_cnt_t'(2));
    assign lsq_pop_2 = (lsq_used >= free_cnt_t'(3));

    // ==============================
    // Source lookup and forwarding
    // ==============================

    always_comb begin
        for (int i = 0; i < `RN_WIDTH; i++) begin
            rs1_p[i] = map_table[rs1_s[i]];
            rs2_p[i] = map_table[rs2_s[i]];
            // Ascending scan, the nearest lower writer is applied last
            for (int j = 0; j < i; j++) begin
                if (writes[j] && (rd_s[j] == rs1_s[i])) begin
                    rs1_p[i] = new_p[j];
                end
                if (writes[j] && (rd_s[j] == rs2_s[i])) begin
                    rs2_p[i] = new_p[j];
                end
            end
            rd_p[i]  = writes[i] ? new_p[i] : '0;
            old_p[i] = map_table[rd_s[i]];
        end
    end

    assign rs1_phys_0    = rs1_p[0];
    assign rs1_phys_1    = rs1_p[1];
    assign rs1_phys_2    = rs1_p[2];
    assign rs2_phys_0    = rs2_p[0];
    assign rs2_phys_1    = rs2_p[1];
    assign rs2_phys_2    = rs2_p[2];
    assign rd_phys_0     = rd_p[0];
    assign rd_phys_1     = rd_p[1];
    assign rd_phys_2     = rd_p[2];
    assign old_rd_phys_0 = old_p[0];
    assign old_rd_phys_1 = old_p[1];
    assign old_rd_phys_2 = old_p[2];

    // ==============================
    // Table update
    // ==============================

    // Later assignments win, so commit restore < rename write < flush
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int a = 0; a < `RN_ARCH_REGS; a++) begin
                map_table[a] <= phys_reg_t'(a);
            end
        end else if (flush) begin
            for (int a = 0; a < `RN_ARCH_REGS; a++) begin
                map_table[a] <= phys_reg_t'(a);
            end
        end else begin
            for (int i = 0; i < `RN_WIDTH; i++) begin
                // Restore only if no younger rename replaced the mapping
                if (commit_valid[i] && (map_table[cm_arch[i]] == cm_phys[i])) begin
                    map_table[cm_arch[i]] <= phys_reg_t'(cm_arch[i]);
                end
            end
            for (int i = 0; i < `RN_WIDTH; i++) begin
                if (writes[i]) begin
                    map_table[rd_s[i]] <= new_p[i];
                end
            end
        end
    end

endmodule

//--- hw/rename_stage.sv
`timescale 1ns/1ps

`include "rename_config.svh"

module rename_stage
    import reg_map_pkg::*;
    import lsq_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    // Decoded group
    input  logic [`RN_WIDTH-1:0] decode_valid,
    input  arch_reg_t            rs1_arch_0, rs1_arch_1, rs1_arch_2,
    input  arch_reg_t            rs2_arch_0, rs2_arch_1, rs2_arch_2,
    input  arch_reg_t            rd_arch_0, rd_arch_1, rd_arch_2,
    input  logic                 rd_write_enable_0, rd_write_enable_1, rd_write_enable_2,
    input  logic                 load_store_0, load_store_1, load_store_2,
    // Commit from the ROB
    input  logic [`RN_WIDTH-1:0] commit_valid,
    input  arch_reg_t            commit_arch_0, commit_arch_1, commit_arch_2,
    input  phys_reg_t            commit_phys_0, commit_phys_1, commit_phys_2,
    // Queue entries handed back
    input  logic [`RN_WIDTH-1:0] lsq_release,
    input  lsq_idx_t             lsq_release_idx_0, lsq_release_idx_1, lsq_release_idx_2,
    // Rename results
    output phys_reg_t            rs1_phys_0, rs1_phys_1, rs1_phys_2,
    output phys_reg_t            rs2_phys_0, rs2_phys_1, rs2_phys_2,
    output phys_reg_t            rd_phys_0, rd_phys_1, rd_phys_2,
    output phys_reg_t            old_rd_phys_0, old_rd_phys_1, old_rd_phys_2,
    output logic [`RN_WIDTH-1:0] rename_valid,
    output logic [`RN_WIDTH-1:0] lsq_alloc_valid,
    output lsq_idx_t             lsq_idx_0, lsq_idx_1, lsq_idx_2,
    output logic [`RN_WIDTH-1:0] rename_ready,
    output logic [`RN_WIDTH-1:0] lsq_alloc_ready
);

    free_cnt_t reg_free_count;
    free_cnt_t lsq_free_count;
    phys_reg_t reg_free_idx_0, reg_free_idx_1, reg_free_idx_2;
    lsq_idx_t  lsq_free_idx_0, lsq_free_idx_1, lsq_free_idx_2;
    logic      reg_pop_0, reg_pop_1, reg_pop_2;
    logic      lsq_pop_0, lsq_pop_1, lsq_pop_2;

    // Free count as a mask of how many slots could be served
    function automatic logic [`RN_WIDTH-1:0] ready_mask(free_cnt_t cnt);
        if (cnt >= free_cnt_t'(3)) begin
            return 3'b111;
        end else if (cnt == free_cnt_t'(2)) begin
            return 3'b011;
        end else if (cnt == free_cnt_t'(1)) begin
            return 3'b001;
        end
        return 3'b000;
    endfunction

    assign rename_ready    = ready_mask(reg_free_count);
    assign lsq_alloc_ready = ready_mask(lsq_free_count);

    // ==============================
    // Mapping table and grant
    // ==============================

    alias_table u_table (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .decode_valid      (decode_valid),
        .rs1_arch_0        (rs1_arch_0),
        .rs1_arch_1        (rs1_arch_1),
        .rs1_arch_2        (rs1_arch_2),
        .rs2_arch_0        (rs2_arch_0),
        .rs2_arch_1        (rs2_arch_1),
        .rs2_arch_2        (rs2_arch_2),
        .rd_arch_0         (rd_arch_0),
        .rd_arch_1         (rd_arch_1),
        .rd_arch_2         (rd_arch_2),
        .rd_write_enable_0 (rd_write_enable_0),
        .rd_write_enable_1 (rd_write_enable_1),
        .rd_write_enable_2 (rd_write_enable_2),
        .load_store_0      (load_store_0),
        .load_store_1      (load_store_1),
        .load_store_2      (load_store_2),
        .reg_free_count    (reg_free_count),
        .lsq_free_count    (lsq_free_count),
        .reg_free_idx_0    (reg_free_idx_0),
        .reg_free_idx_1    (reg_free_idx_1),
        .reg_free_idx_2    (reg_free_idx_2),
        .commit_valid      (commit_valid),
        .commit_arch_0     (commit_arch_0),
        .commit_arch_1     (commit_arch_1),
        .commit_arch_2     (commit_arch_2),
        .commit_phys_0     (commit_phys_0),
        .commit_phys_1     (commit_phys_1),
        .commit_phys_2     (commit_phys_2),
        .rs1_phys_0        (rs1_phys_0),
        .rs1_phys_1        (rs1_phys_1),
        .rs1_phys_2        (rs1_phys_2),
        .rs2_phys_0        (rs2_phys_0),
        .rs2_phys_1        (rs2_phys_1),
        .rs2_phys_2        (rs2_phys_2),
        .rd_phys_0         (rd_phys_0),
        .rd_phys_1         (rd_phys_1),
        .rd_phys_2         (rd_phys_2),
        .old_rd_phys_0     (old_rd_phys_0),
        .old_rd_phys_1     (old_rd_phys_1),
        .old_rd_phys_2     (old_rd_phys_2),
        .rename_valid      (rename_valid),
        .lsq_alloc_valid   (lsq_alloc_valid),
        .reg_pop_0         (reg_pop_0),
        .reg_pop_1         (reg_pop_1),
        .reg_pop_2         (reg_pop_2),
        .lsq_pop_0         (lsq_pop_0),
        .lsq_pop_1         (lsq_pop_1),
        .lsq_pop_2         (lsq_pop_2)
    );

    // ==============================
    // Free lists
    // ==============================

    // Speculative registers only, committed ones are never handed out
    free_index_fifo #(
        .DEPTH (`RN_PHYS_REGS - `RN_ARCH_REGS),
        .FIRST (`RN_ARCH_REGS)
    ) u_reg_free (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .pop_0      (reg_pop_0),
        .pop_1      (reg_pop_1),
        .pop_2      (reg_pop_2),
        .pop_idx_0  (reg_free_idx_0),
        .pop_idx_1  (reg_free_idx_1),
        .pop_idx_2  (reg_free_idx_2),
        .push_0     (commit_valid[0]),
        .push_1     (commit_valid[1]),
        .push_2     (commit_valid[2]),
        .push_idx_0 (commit_phys_0),
        .push_idx_1 (commit_phys_1),
        .push_idx_2 (commit_phys_2),
        .free_count (reg_free_count)
    );

    free_index_fifo #(
        .DEPTH (`RN_LSQ_DEPTH),
        .FIRST (0)
    ) u_lsq_free (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .pop_0      (lsq_pop_0),
        .pop_1      (lsq_pop_1),
        .pop_2      (lsq_pop_2),
        .pop_idx_0  (lsq_free_idx_0),
        .pop_idx_1  (lsq_free_idx_1),
        .pop_idx_2  (lsq_free_idx_2),
        .push_0     (lsq_release[0]),
        .push_1     (lsq_release[1]),
        .push_2     (lsq_release[2]),
        .push_idx_0 (lsq_release_idx_0),
        .push_idx_1 (lsq_release_idx_1),
        .push_idx_2 (lsq_release_idx_2),
        .free_count (lsq_free_count)
    );

    // Queue index per slot, skipping entries taken by lower slots
    // Only meaningful where lsq_alloc_valid is set
    assign lsq_idx_0 = lsq_free_idx_0;
    assign lsq_idx_1 = lsq_alloc_valid[0] ? lsq_free_idx_1 : lsq_free_idx_0;

    always_comb begin
        case (lsq_alloc_valid[1:0])
            2'b00:   lsq_idx_2 = lsq_free_idx_0;
            2'b11:   lsq_idx_2 = lsq_free_idx_2;
            default: lsq_idx_2 = lsq_free_idx_1;
        endcase
    end

endmodule

//--- verif/rename_tb.sv
`timescale 1ns/1ps

`include "rename_config.svh"

module rename_tb
    import reg_map_pkg::*;
    import lsq_pkg::*;
();

    // Reset, per-test cycles with one closing cycle each
    localparam int TEST_CYCLES = 2 + 7 + 3 + 3 + 33 + 9 + 83;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 100;

    logic clk = 1'b0;
    logic reset;
    logic flush;
    logic [`RN_WIDTH-1:0] dv, we, ls, cv, rel;
    arch_reg_t [`RN_WIDTH-1:0] rs1, rs2, rd, ca;
    phys_reg_t [`RN_WIDTH-1:0] cp;
    lsq_idx_t [`RN_WIDTH-1:0] rel_idx;
    phys_reg_t [`RN_WIDTH-1:0] rs1_phys, rs2_phys, rd_phys, old_phys;
    lsq_idx_t [`RN_WIDTH-1:0] lsq_idx;
    logic [`RN_WIDTH-1:0] rename_valid, lsq_alloc_valid, rename_ready, lsq_alloc_ready;

    // Model state and expected outputs of the current cycle
    int model_map [`RN_ARCH_REGS];
    int reg_q[$];
    int lsq_q[$];
    int fly_arch[$];
    int fly_phys[$];
    int fly_lsq[$];
    int e_rs1 [`RN_WIDTH];
    int e_rs2 [`RN_WIDTH];
    int e_rd [`RN_WIDTH];
    int e_old [`RN_WIDTH];
    int e_lsq [`RN_WIDTH];
    logic [`RN_WIDTH-1:0] e_valid, e_wr, e_alloc;
    int e_rdy;
    int e_lsq_rdy;

    string test_name = "reset";
    int test_checks = 0;
    int test_errors = 0;
    int total_checks = 0;
    int total_errors = 0;
    int tests_done = 0;
    int cycle_count = 0;

    rename_stage u_dut (
        .clk(clk), .reset(reset), .flush(flush), .decode_valid(dv),
        .rs1_arch_0(rs1[0]), .rs1_arch_1(rs1[1]), .rs1_arch_2(rs1[2]),
        .rs2_arch_0(rs2[0]), .rs2_arch_1(rs2[1]), .rs2_arch_2(rs2[2]),
        .rd_arch_0(rd[0]), .rd_arch_1(rd[1]), .rd_arch_2(rd[2]),
        .rd_write_enable_0(we[0]), .rd_write_enable_1(we[1]), .rd_write_enable_2(we[2]),
        .load_store_0(ls[0]), .load_store_1(ls[1]), .load_store_2(ls[2]),
        .commit_valid(cv),
        .commit_arch_0(ca[0]), .commit_arch_1(ca[1]), .commit_arch_2(ca[2]),
        .commit_phys_0(cp[0]), .commit_phys_1(cp[1]), .commit_phys_2(cp[2]),
        .lsq_release(rel),
        .lsq_release_idx_0(rel_idx[0]), .lsq_release_idx_1(rel_idx[1]),
        .lsq_release_idx_2(rel_idx[2]),
        .rs1_phys_0(rs1_phys[0]), .rs1_phys_1(rs1_phys[1]), .rs1_phys_2(rs1_phys[2]),
        .rs2_phys_0(rs2_phys[0]), .rs2_phys_1(rs2_phys[1]), .rs2_phys_2(rs2_phys[2]),
        .rd_phys_0(rd_phys[0]), .rd_phys_1(rd_phys[1]), .rd_phys_2(rd_phys[2]),
        .old_rd_phys_0(old_phys[0]), .old_rd_phys_1(old_phys[1]),
        .old_rd_phys_2(old_phys[2]),
        .rename_valid(rename_valid), .lsq_alloc_valid(lsq_alloc_valid),
        .lsq_idx_0(lsq_idx[0]), .lsq_idx_1(lsq_idx[1]), .lsq_idx_2(lsq_idx[2]),
        .rename_ready(rename_ready), .lsq_alloc_ready(lsq_alloc_ready)
    );

    // ==============================
    // Clock and run limit
    // ==============================

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, tests did not finish", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ==============================
    // Reference model
    // ==============================

    task automatic reset_model();
        for (int a = 0; a < `RN_ARCH_REGS; a++) begin
            model_map[a] = a;
        end
        reg_q.delete();
        lsq_q.delete();
        fly_arch.delete();
        fly_phys.delete();
        fly_lsq.delete();
        for (int p = `RN_ARCH_REGS; p < `RN_PHYS_REGS; p++) begin
            reg_q.push_back(p);
        end
        for (int q = 0; q < `RN_LSQ_DEPTH; q++) begin
            lsq_q.push_back(q);
        end
    endtask

    // Expected outputs from this cycle's inputs and the model state
    function automatic void predict();
        int reg_used;
        int lsq_used;
        int need_r;
        int need_l;
        bit stop;
        reg_used = 0;
        lsq_used = 0;
        stop = flush;
        e_valid = '0;
        e_wr = '0;
        e_alloc = '0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            need_r = (dv[i] && we[i] && rd[i] != 0) ? 1 : 0;
            need_l = (dv[i] && ls[i]) ? 1 : 0;
            e_rd[i] = 0;
            e_lsq[i] = 0;
            if (dv[i] && !stop && reg_used + need_r <= reg_q.size()
                && lsq_used + need_l <= lsq_q.size()) begin
                e_valid[i] = 1'b1;
                e_wr[i] = (need_r == 1);
                e_alloc[i] = (need_l == 1);
                e_rd[i] = (need_r == 1) ? reg_q[reg_used] : 0;
                e_lsq[i] = (need_l == 1) ? lsq_q[lsq_used] : 0;
                reg_used += need_r;
                lsq_used += need_l;
            end else if (dv[i]) begin
                stop = 1'b1;
            end
            e_rs1[i] = (rs1[i] == 0) ? 0 : model_map[rs1[i]];
            e_rs2[i] = (rs2[i] == 0) ? 0 : model_map[rs2[i]];
            // Nearest lower writer is applied last
            for (int j = 0; j < i; j++) begin
                if (e_wr[j] && rd[j] == rs1[i]) begin
                    e_rs1[i] = e_rd[j];
                end
                if (e_wr[j] && rd[j] == rs2[i]) begin
                    e_rs2[i] = e_rd[j];
                end
            end
            e_old[i] = model_map[rd[i]];
        end
        e_rdy = (reg_q.size() >= 3) ? 7 : (7 >> (3 - reg_q.size()));
        e_lsq_rdy = (lsq_q.size() >= 3) ? 7 : (7 >> (3 - lsq_q.size()));
    endfunction

    // State after the coming edge
    task automatic advance_model();
        bit restore [`RN_WIDTH];
        if (flush) begin
            reset_model();
        end else begin
            for (int i = 0; i < `RN_WIDTH; i++) begin
                restore[i] = cv[i] && (model_map[ca[i]] == int'(cp[i]));
            end
            for (int i = 0; i < `RN_WIDTH; i++) begin
                if (restore[i]) begin
                    model_map[ca[i]] = int'(ca[i]);
                end
            end
            for (int i = 0; i < `RN_WIDTH; i++) begin
                if (e_wr[i]) begin
                    model_map[rd[i]] = e_rd[i];
                    void'(reg_q.pop_front());
                    fly_arch.push_back(int'(rd[i]));
                    fly_phys.push_back(e_rd[i]);
                end
                if (e_alloc[i]) begin
                    void'(lsq_q.pop_front());
                    fly_lsq.push_back(e_lsq[i]);
                end
            end
            for (int i = 0; i < `RN_WIDTH; i++) begin
                if (cv[i]) begin
                    reg_q.push_back(int'(cp[i]));
                end
                if (rel[i]) begin
                    lsq_q.push_back(int'(rel_idx[i]));
                end
            end
        end
    endtask

    // ==============================
    // Comparison
    // ==============================

    task automatic compare_value(string field, int slot, int exp_val, int act_val);
        test_checks++;
        assert (act_val == exp_val) else begin
            test_errors++;
            $display("Mismatch in %s: %s slot %0d expected %0d actual %0d",
                     test_name, field, slot, exp_val, act_val);
        end
    endtask

    task automatic compare_outputs();
        compare_value("rename_valid", 0, int'(e_valid), int'(rename_valid));
        compare_value("lsq_alloc_valid", 0, int'(e_alloc), int'(lsq_alloc_valid));
        compare_value("rename_ready", 0, e_rdy, int'(rename_ready));
        compare_value("lsq_alloc_ready", 0, e_lsq_rdy, int'(lsq_alloc_ready));
        for (int i = 0; i < `RN_WIDTH; i++) begin
            if (dv[i]) begin
                compare_value("rs1_phys", i, e_rs1[i], int'(rs1_phys[i]));
                compare_value("rs2_phys", i, e_rs2[i], int'(rs2_phys[i]));
                compare_value("old_rd_phys", i, e_old[i], int'(old_phys[i]));
            end
            if (e_wr[i]) begin
                compare_value("rd_phys", i, e_rd[i], int'(rd_phys[i]));
            end
            if (e_alloc[i]) begin
                compare_value("lsq_idx", i, e_lsq[i], int'(lsq_idx[i]));
            end
        end
    endtask

    // Outputs are settled half a period after the inputs change
    always @(negedge clk) begin
        if (reset) begin
            predict();
            compare_outputs();
            advance_model();
        end
    end

    // ==============================
    // Stimulus helpers
    // ==============================

    task automatic idle_inputs();
        flush <= 1'b0;
        dv <= '0;
        we <= '0;
        ls <= '0;
        rs1 <= '0;
        rs2 <= '0;
        rd <= '0;
        cv <= '0;
        ca <= '0;
        cp <= '0;
        rel <= '0;
        rel_idx <= '0;
    endtask

    task automatic begin_cycle();
        @(posedge clk);
        idle_inputs();
    endtask

    task automatic drive_slot(int i, bit v, int s1, int s2, int d, bit w, bit l);
        dv[i] <= v;
        rs1[i] <= arch_reg_t'(s1);
        rs2[i] <= arch_reg_t'(s2);
        rd[i] <= arch_reg_t'(d);
        we[i] <= w;
        ls[i] <= l;
    endtask

    // Oldest renames retire first, as from a ROB
    task automatic commit_oldest(int n);
        for (int k = 0; k < n && fly_phys.size() > 0; k++) begin
            cv[k] <= 1'b1;
            ca[k] <= arch_reg_t'(fly_arch.pop_front());
            cp[k] <= phys_reg_t'(fly_phys.pop_front());
        end
    endtask

    task automatic release_oldest(int n);
        for (int k = 0; k < n && fly_lsq.size() > 0; k++) begin
            rel[k] <= 1'b1;
            rel_idx[k] <= lsq_idx_t'(fly_lsq.pop_front());
        end
    endtask

    task automatic random_group();
        begin_cycle();
        for (int i = 0; i < `RN_WIDTH; i++) begin
            drive_slot(i, ($urandom % 4) != 0, $urandom % 32, $urandom % 32, $urandom % 32,
                       ($urandom % 2) == 1, ($urandom % 3) == 0);
        end
        commit_oldest($urandom % 4);
        release_oldest($urandom % 3);
    endtask

    task automatic end_test();
        begin_cycle();
        $display("Test %s: %0d checks, %0d mismatches", test_name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        tests_done++;
        test_checks = 0;
        test_errors = 0;
    endtask

    // ==============================
    // Tests
    // ==============================

    initial begin
        void'($urandom(95));
        reset <= 1'b0;
        idle_inputs();
        reset_model();
        repeat (2) @(posedge clk);
        reset <= 1'b1;

        test_name = "reset_map";
        for (int c = 0; c < 6; c++) begin
            begin_cycle();
            for (int i = 0; i < `RN_WIDTH; i++) begin
                drive_slot(i, 1'b1, (6 * c + 2 * i) % 32, (6 * c + 2 * i + 1) % 32, 0, 1'b0, 1'b0);
            end
        end
        end_test();

        test_name = "group_alloc";
        begin_cycle();
        for (int i = 0; i < `RN_WIDTH; i++) begin
            drive_slot(i, 1'b1, 1 + i, 2 + i, 5 + i, 1'b1, 1'b0);
        end
        begin_cycle();
        for (int i = 0; i < `RN_WIDTH; i++) begin
            drive_slot(i, 1'b1, 5 + i, 7 - i, 0, 1'b0, 1'b0);
        end
        end_test();

        // Two writers of x10, then an x0 writer that must not forward
        test_name = "forwarding";
        begin_cycle();
        drive_slot(0, 1'b1, 3, 4, 10, 1'b1, 1'b0);
        drive_slot(1, 1'b1, 10, 3, 10, 1'b1, 1'b0);
        drive_slot(2, 1'b1, 10, 0, 0, 1'b1, 1'b0);
        begin_cycle();
        drive_slot(0, 1'b1, 10, 1, 0, 1'b1, 1'b0);
        drive_slot(1, 1'b1, 0, 10, 0, 1'b0, 1'b0);
        drive_slot(2, 1'b1, 10, 0, 0, 1'b0, 1'b0);
        end_test();

        // 27 registers left, single writes walk the mask through 011 and 001
        test_name = "exhaustion";
        for (int c = 0; c < 12; c++) begin
            begin_cycle();
            for (int i = 0; i < `RN_WIDTH; i++) begin
                drive_slot(i, 1'b1, i + 1, 20, 11 + (3 * c + i) % 15,
                           i < ((c == 8 || c == 9) ? 1 : 3), 1'b0);
            end
        end
        for (int c = 0; c < 12; c++) begin
            begin_cycle();
            for (int i = 0; i < `RN_WIDTH; i++) begin
                drive_slot(i, 1'b1, i, i + 1, 0, 1'b0, i < ((c == 10) ? 1 : 3));
            end
        end
        for (int c = 0; c < 4; c++) begin
            begin_cycle();
            release_oldest(3);
        end
        for (int c = 0; c < 4; c++) begin
            begin_cycle();
            for (int i = 0; i < `RN_WIDTH; i++) begin
                drive_slot(i, 1'b1, i, 0, 0, 1'b0, 1'b1);
            end
        end
        end_test();

        // x5 to x7 and the second x10 restore, the first x10 and x11 do not
        test_name = "commit_restore";
        begin_cycle();
        commit_oldest(3);
        begin_cycle();
        commit_oldest(3);
        begin_cycle();
        drive_slot(0, 1'b1, 5, 6, 0, 1'b0, 1'b0);
        drive_slot(1, 1'b1, 7, 10, 0, 1'b0, 1'b0);
        drive_slot(2, 1'b1, 11, 0, 0, 1'b0, 1'b0);
        for (int c = 0; c < 5; c++) begin
            begin_cycle();
            commit_oldest(3);
            for (int i = 0; i < `RN_WIDTH; i++) begin
                drive_slot(i, 1'b1, 20 + i, 22 - i, 20 + i, 1'b1, 1'b0);
            end
        end
        end_test();

        test_name = "flush_random";
        for (int c = 0; c < 40; c++) begin
            random_group();
        end
        random_group();
        flush <= 1'b1;
        for (int c = 0; c < 41; c++) begin
            random_group();
        end
        end_test();

        $display("Tests: %0d, checks: %0d, mismatches: %0d", tests_done, total_checks,
                 total_errors);
        if (total_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
hw/reg_map_pkg.sv
hw/lsq_pkg.sv
hw/free_index_fifo.sv
hw/alias_table.sv
hw/rename_stage.sv
verif/rename_tb.sv

//--- Makefile
TOP := rename_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module rename_stage
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --assert -j 0 -f vlog.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
